// File: src.f
+incdir+src
src/lsu_access_pkg.sv
src/lsu_ctrl_pkg.sv
src/lsu_request_gen.sv
src/lsu_resp_ctx.sv
src/lsu_load_align.sv
src/lsu_transfer_fsm.sv
src/load_store_unit.sv
sim/tb_load_store_unit.sv

// File: sim/tb_load_store_unit.sv
////////////////////
// load/store unit testbench
//   memory model with random grant and response delay
//   random and directed loads and stores
//   concurrent checks, watchdog, final report
////////////////////

`timescale 1ns/1ps

module tb_load_store_unit;

  import lsu_access_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 5;
  localparam int RANDOM_CYCLES  = 200; // request-free cycles for the datapath checks
  localparam int RANDOM_TXN     = 40;
  localparam int DIRECTED_TXN   = 64;  // every size, offset and fill mode
  localparam int NUM_TXN        = DIRECTED_TXN + RANDOM_TXN + 2;
  // a transaction can be split in two accesses
  localparam int TIMEOUT_CYCLES = 2 * NUM_TXN * 10 + RANDOM_CYCLES + RESET_CYCLES + 100;

  logic clk;
  logic rst_n;
  logic data_req_ex_i, addr_useincr_ex_i, data_we_ex_i, data_misaligned_ex_i, ex_valid_i;
  lsu_data_t operand_a_ex_i, operand_b_ex_i, data_wdata_ex_i, data_rdata_ex_o;
  lsu_size_e data_type_ex_i;
  lsu_ofs_t  data_reg_offset_ex_i;
  lsu_ext_e  data_sign_ext_ex_i;
  logic data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  lsu_addr_t data_addr_o;
  lsu_be_t   data_be_o;
  lsu_data_t data_wdata_o, data_rdata_i;

  lsu_data_t mem [0:15]; // model memory indexed by address bits 5:2
  int unsigned gnt_delay, wait_cnt;
  int unsigned resp_delay, resp_cnt; // extra cycles before rvalid

  // expectations derived from the pipeline inputs
  lsu_addr_t exp_addr;
  logic      exp_mis;

  // bookkeeping of the access in flight
  logic      outstanding, wb_wait, ex_stalled, held_valid;
  logic      acc_first, acc_we;
  lsu_addr_t acc_start; // byte address the load result starts at
  lsu_size_e acc_size;
  lsu_ext_e  acc_ext;
  lsu_data_t held_exp;

  load_store_unit load_store_unit_inst (.*);

  assign exp_addr = addr_useincr_ex_i ? operand_a_ex_i + operand_b_ex_i : operand_a_ex_i;
  assign exp_mis  = data_req_ex_i && !data_misaligned_ex_i &&
                    ((data_type_ex_i == SIZE_WORD && exp_addr[1:0] != 2'b00) ||
                     (data_type_ex_i == SIZE_HALF && exp_addr[1:0] == 2'b11));

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic lsu_be_t lane_enables(input lsu_size_e size, input lsu_ofs_t ofs,
                                           input logic second);
    lsu_be_t be;
    int      lane;
    int      o;
    o = ofs;
    for (lane = 0; lane < 4; lane++)
    begin
      if (size == SIZE_WORD)
        be[lane] = second ? (lane < o) : (lane >= o);
      else if (size == SIZE_HALF)
        be[lane] = second ? (lane == 0) : (lane == o || lane == o + 1); // lane 4 never exists
      else
        be[lane] = (lane == o);
    end
    return be;
  endfunction

  // register byte i lands in memory lane i + (mem lane - reg lane)
  function automatic lsu_data_t rotate_left_bytes(input lsu_data_t d, input lsu_ofs_t mem_ofs,
                                                  input lsu_ofs_t reg_ofs);
    lsu_data_t r;
    int        i;
    int        rot;
    rot = (4 + int'(mem_ofs) - int'(reg_ofs)) % 4;
    for (i = 0; i < 4; i++)
      r[((i + rot) % 4) * 8 +: 8] = d[i * 8 +: 8];
    return r;
  endfunction

  function automatic logic [7:0] mem_byte(input lsu_addr_t a);
    lsu_data_t word;
    word = mem[a[5:2]];
    return word[a[1:0] * 8 +: 8];
  endfunction

  // bytes from the start address upward and then zero/one/sign fill
  function automatic lsu_data_t load_result(input lsu_addr_t start, input lsu_size_e size,
                                            input lsu_ext_e ext);
    lsu_data_t  val;
    logic [7:0] top;
    logic       fill;
    int         nbytes;
    int         k;
    nbytes = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
    top    = mem_byte(start + lsu_addr_t'(nbytes - 1));
    fill   = (ext == EXT_ONES) || ((ext == EXT_SIGN || ext == EXT_SIGN_ALT) && top[7]);
    for (k = 0; k < 4; k++)
      val[k * 8 +: 8] = (k < nbytes) ? mem_byte(start + lsu_addr_t'(k)) : {8{fill}};
    return val;
  endfunction

  task automatic drive_request(input lsu_addr_t addr, input logic we, input lsu_size_e size,
                               input lsu_ext_e ext, input logic second);
    logic      use_incr;
    lsu_data_t incr;
    use_incr = 1'($urandom_range(0, 1));
    incr     = $urandom;
    operand_a_ex_i       <= use_incr ? addr - incr : addr;
    operand_b_ex_i       <= incr;
    addr_useincr_ex_i    <= use_incr;
    data_we_ex_i         <= we;
    data_type_ex_i       <= size;
    data_sign_ext_ex_i   <= ext;
    data_wdata_ex_i      <= $urandom;
    data_reg_offset_ex_i <= lsu_ofs_t'($urandom_range(0, 3));
    data_misaligned_ex_i <= second;
    data_req_ex_i        <= 1'b1;
  endtask

  task automatic wait_for_grant;
    do @(negedge clk); while (!(data_req_o && data_gnt_i));
    @(posedge clk);
  endtask

  task automatic wait_for_rvalid;
    do @(negedge clk); while (!data_rvalid_i);
    @(posedge clk);
  endtask

  // one pipeline access that splits in two memory accesses when it crosses a word
  task automatic perform_access(input lsu_addr_t addr, input logic we, input lsu_size_e size,
                                input lsu_ext_e ext);
    logic split;
    split = (size == SIZE_WORD && addr[1:0] != 2'b00) ||
            (size == SIZE_HALF && addr[1:0] == 2'b11);
    drive_request(addr, we, size, ext, 1'b0);
    wait_for_grant();
    if (split)
    begin
      wait_for_rvalid(); // ex stage holds the first part through its response
      drive_request(addr + 4, we, size, ext, 1'b1);
      wait_for_grant();
    end
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    wait_for_rvalid();
  endtask

  ////////////////////
  // clock, memory model, tracking
  ////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // grant after 0..2 extra cycles and rvalid 1..2 cycles after the grant
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      wait_cnt      <= 0;
      gnt_delay     <= $urandom_range(0, 2);
      resp_cnt      <= 0;
      resp_delay    <= $urandom_range(0, 1);
    end
    else
    begin
      data_rvalid_i <= 1'b0;
      if (resp_cnt != 0)
      begin
        resp_cnt <= resp_cnt - 1;
        if (resp_cnt == 1)
          data_rvalid_i <= 1'b1; // delayed response
      end
      if (data_req_o && data_gnt_i)
      begin
        data_gnt_i   <= 1'b0;
        data_rdata_i <= mem[data_addr_o[5:2]];
        if (resp_delay == 0)
          data_rvalid_i <= 1'b1;
        else
          resp_cnt <= resp_delay;
        resp_delay   <= $urandom_range(0, 1);
        wait_cnt     <= 0;
        gnt_delay    <= $urandom_range(0, 2);
      end
      else if (data_req_o)
      begin
        if (wait_cnt >= gnt_delay)
          data_gnt_i <= 1'b1;
        else
          wait_cnt <= wait_cnt + 1;
      end
      else
        data_gnt_i <= 1'b0; // grant only beside a request
    end
  end

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      outstanding <= 1'b0;
      wb_wait     <= 1'b0;
      ex_stalled  <= 1'b0;
      held_valid  <= 1'b1; // result register starts at zero
      held_exp    <= '0;
      acc_first   <= 1'b0;
      acc_we      <= 1'b0;
    end
    else
    begin
      if (data_rvalid_i)
      begin
        outstanding <= 1'b0;
        if (!acc_we)
        begin
          held_valid <= !acc_first; // first part leaves the raw word behind
          held_exp   <= load_result(acc_start, acc_size, acc_ext);
        end
      end
      if (data_req_o && data_gnt_i)
      begin
        outstanding <= 1'b1;
        wb_wait     <= ex_valid_i;
        acc_first   <= exp_mis;
        acc_we      <= data_we_ex_i;
        acc_size    <= data_type_ex_i;
        acc_ext     <= data_sign_ext_ex_i;
        acc_start   <= data_misaligned_ex_i ? exp_addr - 4 : exp_addr;
      end
      if (data_req_o && data_gnt_i && !ex_valid_i)
        ex_stalled <= 1'b1;
      else if (ex_valid_i)
        ex_stalled <= 1'b0;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_addr: assert property (@(posedge clk) disable iff (!rst_n) data_addr_o == exp_addr)
    else stop_on_error($sformatf("FAIL %0t: data_addr_o differs from operand sum", $time));
  a_be: assert property (@(posedge clk) disable iff (!rst_n)
    data_be_o == lane_enables(data_type_ex_i, exp_addr[1:0], data_misaligned_ex_i))
    else stop_on_error($sformatf("FAIL %0t: data_be_o wrong for size and offset", $time));
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    data_wdata_o == rotate_left_bytes(data_wdata_ex_i, exp_addr[1:0], data_reg_offset_ex_i))
    else stop_on_error($sformatf("FAIL %0t: data_wdata_o lane rotation wrong", $time));
  a_we: assert property (@(posedge clk) disable iff (!rst_n) data_we_o == data_we_ex_i)
    else stop_on_error($sformatf("FAIL %0t: data_we_o does not follow ex stage", $time));
  a_mis: assert property (@(posedge clk) disable iff (!rst_n) data_misaligned_o == exp_mis)
    else stop_on_error($sformatf("FAIL %0t: data_misaligned_o wrong", $time));
  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    (data_rvalid_i && !acc_we && !acc_first) |->
      data_rdata_ex_o == load_result(acc_start, acc_size, acc_ext))
    else stop_on_error($sformatf("FAIL %0t: load data wrong in rvalid cycle", $time));
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (held_valid && !data_rvalid_i) |-> data_rdata_ex_o == held_exp)
    else stop_on_error($sformatf("FAIL %0t: held load result changed", $time));
  a_rdy_ex_low: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |-> !lsu_ready_ex_o)
    else stop_on_error($sformatf("FAIL %0t: lsu_ready_ex_o high without grant", $time));
  a_rdy_ex_high: assert property (@(posedge clk) disable iff (!rst_n)
    !data_req_ex_i |-> lsu_ready_ex_o)
    else stop_on_error($sformatf("FAIL %0t: lsu_ready_ex_o low with no request", $time));
  // a grant taken under an ex stall leaves wb free
  a_rdy_wb_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding && wb_wait && !data_rvalid_i) |-> !lsu_ready_wb_o)
    else stop_on_error($sformatf("FAIL %0t: lsu_ready_wb_o high before rvalid", $time));
  a_rdy_wb_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (!outstanding || data_rvalid_i) |-> lsu_ready_wb_o)
    else stop_on_error($sformatf("FAIL %0t: lsu_ready_wb_o low with no wait", $time));
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding || (data_req_ex_i && !ex_stalled)) |-> busy_o)
    else stop_on_error($sformatf("FAIL %0t: busy_o low during an access", $time));
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (!outstanding && !ex_stalled && !data_req_ex_i) |-> !busy_o)
    else stop_on_error($sformatf("FAIL %0t: busy_o high while idle", $time));
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_stalled && !ex_valid_i) |-> !data_req_o)
    else stop_on_error($sformatf("FAIL %0t: data_req_o raised during ex stall", $time));
  // one request in flight and the next one only in the rvalid cycle
  a_single: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding && !data_rvalid_i) |-> !data_req_o)
    else stop_on_error($sformatf("FAIL %0t: second request while one outstanding", $time));

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    lsu_addr_t addr;
    int        s;
    int        o;
    int        e;
    void'($urandom(32'hbe70));
    for (s = 0; s < 16; s++)
      mem[s] = 32'h9e37_79b9 * (s + 1) ^ (s << 27); // varies in every byte and sign bit
    rst_n = 1'b0;
    {data_req_ex_i, addr_useincr_ex_i, data_we_ex_i, data_misaligned_ex_i} = '0;
    ex_valid_i           = 1'b1;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    data_wdata_ex_i      = '0;
    data_type_ex_i       = SIZE_WORD;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i   = EXT_ZERO;
    data_gnt_i           = 1'b0;
    data_rvalid_i        = 1'b0;
    data_rdata_i         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // datapath only while no request reaches memory
    repeat (RANDOM_CYCLES)
    begin
      @(posedge clk);
      operand_a_ex_i       <= $urandom;
      operand_b_ex_i       <= $urandom;
      addr_useincr_ex_i    <= 1'($urandom_range(0, 1));
      data_we_ex_i         <= 1'($urandom_range(0, 1));
      data_type_ex_i       <= lsu_size_e'($urandom_range(0, 3));
      data_sign_ext_ex_i   <= lsu_ext_e'($urandom_range(0, 3));
      data_wdata_ex_i      <= $urandom;
      data_reg_offset_ex_i <= lsu_ofs_t'($urandom_range(0, 3));
      data_misaligned_ex_i <= 1'($urandom_range(0, 1));
    end

    // every size, offset and fill mode with the crossing ones run as split loads
    for (s = 0; s < 4; s++)
      for (o = 0; o < 4; o++)
        for (e = 0; e < 4; e++)
        begin
          addr = {$urandom_range(0, 15), 2'b00} + o;
          perform_access(addr, 1'b0, lsu_size_e'(s), lsu_ext_e'(e));
        end

    repeat (RANDOM_TXN)
      perform_access($urandom, 1'($urandom_range(0, 1)), lsu_size_e'($urandom_range(0, 3)),
                     lsu_ext_e'($urandom_range(0, 3)));

    // load granted under an ex stall so the next request waits for ex_valid
    ex_valid_i <= 1'b0;
    drive_request($urandom & ~32'h3, 1'b0, SIZE_WORD, EXT_ZERO, 1'b0);
    wait_for_grant();
    drive_request($urandom & ~32'h3, 1'b0, SIZE_BYTE, EXT_SIGN, 1'b0);
    wait_for_rvalid();
    repeat (3) @(posedge clk);
    ex_valid_i <= 1'b1;
    wait_for_grant();
    data_req_ex_i <= 1'b0;
    wait_for_rvalid();

    repeat (3) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    stop_on_error("watchdog expired, an access never completed");
  end

endmodule

// File: src/load_store_unit.sv
////////////////////
// load/store unit top level
//   request datapath, response context,
//   load aligner and transfer FSM
////////////////////

`timescale 1ns/1ps

`include "lsu_config.svh"

module load_store_unit
(
  input  logic                      clk,
  input  logic                      rst_n,

  // ex stage
  input  logic                      data_req_ex_i,
  input  lsu_access_pkg::lsu_data_t operand_a_ex_i,
  input  lsu_access_pkg::lsu_data_t operand_b_ex_i,
  input  logic                      addr_useincr_ex_i,
  input  logic                      data_we_ex_i,
  input  lsu_access_pkg::lsu_size_e data_type_ex_i,
  input  lsu_access_pkg::lsu_data_t data_wdata_ex_i,
  input  lsu_access_pkg::lsu_ofs_t  data_reg_offset_ex_i,
  input  lsu_access_pkg::lsu_ext_e  data_sign_ext_ex_i,
  input  logic                      data_misaligned_ex_i,
  input  logic                      ex_valid_i,
  output lsu_access_pkg::lsu_data_t data_rdata_ex_o,
  output logic                      data_misaligned_o,
  output logic                      lsu_ready_ex_o,
  output logic                      lsu_ready_wb_o,
  output logic                      busy_o,

  // data memory
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output lsu_access_pkg::lsu_addr_t data_addr_o,
  output logic                      data_we_o,
  output lsu_access_pkg::lsu_be_t   data_be_o,
  output lsu_access_pkg::lsu_data_t data_wdata_o,
  input  lsu_access_pkg::lsu_data_t data_rdata_i
);

  lsu_access_pkg::lsu_ofs_t  addr_ofs;   // lane of the current request
  lsu_access_pkg::lsu_size_e size_q;
  lsu_access_pkg::lsu_ofs_t  offset_q;
  lsu_access_pkg::lsu_ext_e  ext_q;
  logic                      we_q;

  assign addr_ofs  = data_addr_o[`LSU_OFS_W-1:0];
  assign data_we_o = data_we_ex_i; // direction goes straight to memory

  lsu_request_gen lsu_request_gen_inst (
    .operand_a_i     (operand_a_ex_i),
    .operand_b_i     (operand_b_ex_i),
    .addr_useincr_i  (addr_useincr_ex_i),
    .size_i          (data_type_ex_i),
    .data_wdata_i    (data_wdata_ex_i),
    .reg_offset_i    (data_reg_offset_ex_i),
    .req_i           (data_req_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .addr_o          (data_addr_o),
    .be_o            (data_be_o),
    .wdata_o         (data_wdata_o),
    .misaligned_o    (data_misaligned_o)
  );

  lsu_resp_ctx lsu_resp_ctx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .gnt_i      (data_gnt_i),
    .size_i     (data_type_ex_i),
    .offset_i   (addr_ofs),
    .ext_i      (data_sign_ext_ex_i),
    .we_i       (data_we_ex_i),
    .size_q_o   (size_q),
    .offset_q_o (offset_q),
    .ext_q_o    (ext_q),
    .we_q_o     (we_q)
  );

  lsu_load_align lsu_load_align_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .rvalid_i        (data_rvalid_i),
    .rdata_i         (data_rdata_i),
    .size_q_i        (size_q),
    .offset_q_i      (offset_q),
    .ext_q_i         (ext_q),
    .we_q_i          (we_q),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i    (data_misaligned_o),
    .rdata_o         (data_rdata_ex_o)
  );

  lsu_transfer_fsm lsu_transfer_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (data_req_ex_i),
    .gnt_i      (data_gnt_i),
    .rvalid_i   (data_rvalid_i),
    .ex_valid_i (ex_valid_i),
    .data_req_o (data_req_o),
    .ready_ex_o (lsu_ready_ex_o),
    .ready_wb_o (lsu_ready_wb_o),
    .busy_o     (busy_o)
  );

endmodule

// File: src/lsu_transfer_fsm.sv
////////////////////
// transfer control FSM
//   request issue on the memory port
//   ex stage stall tracking
//   ready and busy outputs
////////////////////

`timescale 1ns/1ps

module lsu_transfer_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,      // access requested by ex stage
  input  logic gnt_i,      // memory accepted the request
  input  logic rvalid_i,   // memory response
  input  logic ex_valid_i, // ex stage is moving on this cycle
  output logic data_req_o,
  output logic ready_ex_o, // ex stage may proceed
  output logic ready_wb_o, // wb stage may proceed
  output logic busy_o
);

  import lsu_ctrl_pkg::*;

  lsu_state_e state_q, state_d;

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // next state and outputs
  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = req_i;
        if (req_i)
        begin
          ready_ex_o = gnt_i; // hold ex until the memory takes the request
          if (gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        ready_wb_o = rvalid_i; // wb waits for the response
        if (rvalid_i)
        begin
          data_req_o = req_i; // back-to-back issue in the rvalid cycle
          if (req_i && gnt_i)
          begin
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
          end
          else
          begin
            ready_ex_o = !req_i; // pending request, not granted yet
            state_d    = IDLE;
          end
        end
      end

      // response outstanding while ex is stalled, no new issue here
      WAIT_RVALID_EX_STALL:
      begin
        if (rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID; // stall gone, continue as a normal wait
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
        state_d = IDLE;
    endcase
  end

  // busy from the request until the pipeline has moved past the access
  assign busy_o = (state_q != IDLE) || data_req_o;

endmodule

// File: src/lsu_load_align.sv
////////////////////
// load data aligner
//   word / halfword / byte lane selection
//   zero, one or sign fill of narrow loads
//   assembly of the two parts of a misaligned load
//   held load result
////////////////////

`timescale 1ns/1ps

`include "lsu_config.svh"

module lsu_load_align
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rvalid_i,        // memory response valid
  input  lsu_access_pkg::lsu_data_t rdata_i,         // raw memory word
  input  lsu_access_pkg::lsu_size_e size_q_i,
  input  lsu_access_pkg::lsu_ofs_t  offset_q_i,
  input  lsu_access_pkg::lsu_ext_e  ext_q_i,
  input  logic                      we_q_i,
  input  logic                      misaligned_ex_i, // second part in flight
  input  logic                      misaligned_i,    // first part of a split access
  output lsu_access_pkg::lsu_data_t rdata_o
);

  import lsu_access_pkg::*;

  lsu_data_t rdata_q;   // held result, or first part of a split load
  lsu_data_t rdata_ext; // aligned and filled result

  logic [2*`LSU_DATA_W-1:0] rdata_win; // new word above held word
  logic [2*`LSU_DATA_W-1:0] win_shift;
  lsu_data_t                cur_shift; // new word moved down to the offset

  lsu_data_t   word_val;
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  logic        half_fill; // bit used for the upper 16 bits
  logic        byte_fill; // bit used for the upper 24 bits

  ////////////////////
  // lane selection
  ////////////////////

  assign rdata_win = {rdata_i, rdata_q};
  assign win_shift = rdata_win >> {offset_q_i, 3'b000};
  assign cur_shift = rdata_i >> {offset_q_i, 3'b000};

  // offset 0 is a plain word, otherwise upper bytes of the first part sit below
  assign word_val = (offset_q_i == '0) ? rdata_i : win_shift[`LSU_DATA_W-1:0];

  // halfword at lane 3 takes new byte 0 above held byte 3
  assign half_raw = (offset_q_i == 2'b11) ? win_shift[15:0] : cur_shift[15:0];
  assign byte_raw = cur_shift[7:0];

  ////////////////////
  // fill
  ////////////////////

  always_comb
  begin
    case (ext_q_i)
      EXT_ZERO:
      begin
        half_fill = 1'b0;
        byte_fill = 1'b0;
      end
      EXT_ONES:
      begin
        half_fill = 1'b1;
        byte_fill = 1'b1;
      end
      default:
      begin
        half_fill = half_raw[15]; // sign of the halfword
        byte_fill = byte_raw[7];
      end
    endcase
  end

  always_comb
  begin
    case (size_q_i)
      SIZE_WORD: rdata_ext = word_val;
      SIZE_HALF: rdata_ext = {{16{half_fill}}, half_raw};
      default:   rdata_ext = {{24{byte_fill}}, byte_raw};
    endcase
  end

  // result register, raw word kept while a split load is in progress
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rvalid_i && !we_q_i)
    begin
      if (misaligned_ex_i || misaligned_i)
        rdata_q <= rdata_i;   // first part, assembled on the next response
      else
        rdata_q <= rdata_ext; // final value for the register file
    end
  end

  assign rdata_o = rvalid_i ? rdata_ext : rdata_q; // live in the rvalid cycle, held after

endmodule

// File: src/lsu_resp_ctx.sv
////////////////////
// response context register
//   keeps size, offset, fill mode and direction
//   of the last granted access for the aligner
////////////////////

`timescale 1ns/1ps

module lsu_resp_ctx
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      gnt_i,      // request accepted this cycle
  input  lsu_access_pkg::lsu_size_e size_i,
  input  lsu_access_pkg::lsu_ofs_t  offset_i,   // address lane of the request
  input  lsu_access_pkg::lsu_ext_e  ext_i,
  input  logic                      we_i,
  output lsu_access_pkg::lsu_size_e size_q_o,
  output lsu_access_pkg::lsu_ofs_t  offset_q_o,
  output lsu_access_pkg::lsu_ext_e  ext_q_o,
  output logic                      we_q_o      // high for a store, no data to align
);

  import lsu_access_pkg::*;

  // load on every grant, response arrives later
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q_o   <= SIZE_WORD;
      offset_q_o <= '0;
      ext_q_o    <= EXT_ZERO;
      we_q_o     <= 1'b0;
    end
    else if (gnt_i)
    begin
      size_q_o   <= size_i;
      offset_q_o <= offset_i;
      ext_q_o    <= ext_i;
      we_q_o     <= we_i;
    end
  end

endmodule

// File: src/lsu_request_gen.sv
////////////////////
// request side datapath
//   address generation from the operands
//   byte enable tables, first and second part
//   store data lane rotation
//   misaligned access detection
////////////////////

`timescale 1ns/1ps

`include "lsu_config.svh"

module lsu_request_gen
(
  input  lsu_access_pkg::lsu_data_t operand_a_i,     // base operand
  input  lsu_access_pkg::lsu_data_t operand_b_i,     // increment operand
  input  logic                      addr_useincr_i,  // a + b when high, a alone otherwise
  input  lsu_access_pkg::lsu_size_e size_i,          // word / half / byte
  input  lsu_access_pkg::lsu_data_t data_wdata_i,    // store data as held in the register
  input  lsu_access_pkg::lsu_ofs_t  reg_offset_i,    // lane offset inside the register
  input  logic                      req_i,           // access requested by ex stage
  input  logic                      misaligned_ex_i, // this is the second part of an access
  output lsu_access_pkg::lsu_addr_t addr_o,
  output lsu_access_pkg::lsu_be_t   be_o,
  output lsu_access_pkg::lsu_data_t wdata_o,
  output logic                      misaligned_o     // a second access will be needed
);

  import lsu_access_pkg::*;

  lsu_ofs_t addr_ofs;    // byte lane the address points at
  lsu_ofs_t rot_ofs;     // store data rotation in bytes
  lsu_be_t  be_from_ofs; // lanes from the offset up to the top lane

  logic [2*`LSU_DATA_W-1:0] wdata_dbl; // doubled word, upper half is the rotation

  ////////////////////
  // address
  ////////////////////

  assign addr_o   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_ofs = addr_o[`LSU_OFS_W-1:0];

  ////////////////////
  // byte enables
  ////////////////////

  // shifted all-ones mask, the top lanes fall out of the vector
  assign be_from_ofs = {`LSU_BE_W{1'b1}} << addr_ofs;

  always_comb
  begin
    case (size_i)
      SIZE_WORD:
      begin
        if (!misaligned_ex_i)
          be_o = be_from_ofs;  // lanes offset..3
        else
          be_o = ~be_from_ofs; // remaining lanes below the offset
      end
      SIZE_HALF:
      begin
        if (!misaligned_ex_i)
          be_o = lsu_be_t'(2'b11) << addr_ofs; // clipped at lane 3
        else
          be_o = lsu_be_t'(1'b1); // second part only holds lane 0
      end
      default:
        be_o = lsu_be_t'(1'b1) << addr_ofs; // single byte lane
    endcase
  end

  ////////////////////
  // store data
  ////////////////////

  // memory lane minus register lane, wraps modulo 4
  assign rot_ofs = addr_ofs - reg_offset_i;

  // rotate left by whole bytes
  assign wdata_dbl = {data_wdata_i, data_wdata_i} << {rot_ofs, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_DATA_W-1 -: `LSU_DATA_W];

  // misaligned detection, only on the first part of an access
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i && !misaligned_ex_i)
    begin
      case (size_i)
        SIZE_WORD: misaligned_o = (addr_ofs != '0);      // word not on a word boundary
        SIZE_HALF: misaligned_o = (addr_ofs == 2'b11);   // halfword spills into next word
        default:   misaligned_o = 1'b0;                  // a byte never crosses
      endcase
    end
  end

endmodule

// File: src/lsu_ctrl_pkg.sv
////////////////////
// transfer control types
//   state encoding of the request FSM
////////////////////

package lsu_ctrl_pkg;

  // IDLE_EX_STALL: response done, pipeline still stalled
  typedef enum logic [1:0] {
    IDLE, WAIT_RVALID, WAIT_RVALID_EX_STALL, IDLE_EX_STALL
  } lsu_state_e;

endpackage

// File: src/lsu_access_pkg.sv
////////////////////
// types describing a single memory access
//   data, address, byte enable, byte offset
//   access size and load fill mode
////////////////////

`include "lsu_config.svh"

package lsu_access_pkg;

  typedef logic [`LSU_DATA_W-1:0] lsu_data_t; // data word
  typedef logic [`LSU_DATA_W-1:0] lsu_addr_t; // byte address
  typedef logic [`LSU_BE_W-1:0]   lsu_be_t;   // one bit per byte lane
  typedef logic [`LSU_OFS_W-1:0]  lsu_ofs_t;  // lane inside a word

  // access size, both byte codes behave the same
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00, SIZE_HALF = 2'b01, SIZE_BYTE = 2'b10, SIZE_BYTE_ALT = 2'b11
  } lsu_size_e;

  // how the upper bits of a narrow load get filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00, EXT_SIGN = 2'b01, EXT_ONES = 2'b10, EXT_SIGN_ALT = 2'b11
  } lsu_ext_e;

endpackage

// File: src/lsu_config.svh
////////////////////
// load/store unit build constants
//   data/address width, byte-enable width,
//   byte offset width inside a word
////////////////////

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// one data word, also used for byte addresses
`define LSU_DATA_W 32

// one enable per byte lane of a data word
`define LSU_BE_W 4

// selects a byte lane inside a word
`define LSU_OFS_W 2

`endif
